// File: rename_pkg.sv
package rename_pkg;

    // Register file sizes
    parameter int NUM_ARCH = 32;
    parameter int NUM_PHYS = 64;

    parameter int ARCH_W = $clog2(NUM_ARCH);
    parameter int PHYS_W = $clog2(NUM_PHYS);

    // Sized for the default ROB_DEPTH of 8
    parameter int ROB_ID_W = 3;

    typedef logic [ARCH_W-1:0]   arch_reg_t;
    typedef logic [PHYS_W-1:0]   phys_reg_t;
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // Whole map, one physical register per architectural register
    typedef phys_reg_t [NUM_ARCH-1:0] map_vec_t;

    // Instruction from the decoder
    typedef struct packed {
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
    } ren_inst_t;

    // Instruction after renaming
    typedef struct packed {
        rob_id_t   rob_id;
        phys_reg_t prd;
        phys_reg_t prs1;
        phys_reg_t prs2;
        phys_reg_t old_prd;
    } renamed_t;

    // Retiring instruction, also the reorder buffer entry payload
    typedef struct packed {
        arch_reg_t rd;
        phys_reg_t prd;
        phys_reg_t old_prd;
    } commit_t;

endpackage

// File: spec_map_table.sv
`timescale 1ns/1ps

module spec_map_table (
    input  logic                 clk,
    input  logic                 rst,

    // Lookups for the instruction being renamed
    input  rename_pkg::arch_reg_t rs1,
    input  rename_pkg::arch_reg_t rs2,
    input  rename_pkg::arch_reg_t rd,
    output rename_pkg::phys_reg_t prs1,
    output rename_pkg::phys_reg_t prs2,
    output rename_pkg::phys_reg_t old_prd,

    // New mapping for rd
    input  logic                 map_we,
    input  rename_pkg::phys_reg_t new_prd,

    // Recovery from the committed state
    input  logic                 flush,
    input  rename_pkg::map_vec_t  retired_map
);

    rename_pkg::map_vec_t map_q;

    // Three combinational read ports
    assign prs1    = map_q[rs1];
    assign prs2    = map_q[rs2];
    assign old_prd = map_q[rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map out of reset
            for (int i = 0; i < rename_pkg::NUM_ARCH; i++) begin
                map_q[i] <= rename_pkg::phys_reg_t'(i);
            end
        end else if (flush) begin
            // Restore wins over a same-cycle write
            map_q <= retired_map;
        end else if (map_we) begin
            map_q[rd] <= new_prd;
        end
    end

endmodule

// File: retire_map_table.sv
`timescale 1ns/1ps

module retire_map_table (
    input  logic                clk,
    input  logic                rst,
    input  logic                commit_valid,
    input  rename_pkg::commit_t commit_info,
    output rename_pkg::map_vec_t retired_map
);

    rename_pkg::map_vec_t map_q;

    // x0 stays mapped to physical 0
    logic commit_we;
    assign commit_we = commit_valid && (commit_info.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::NUM_ARCH; i++) begin
                map_q[i] <= rename_pkg::phys_reg_t'(i);
            end
        end else if (commit_we) begin
            map_q[commit_info.rd] <= commit_info.prd;
        end
    end

    // Whole table goes to the speculative map for flush recovery
    assign retired_map = map_q;

endmodule

// File: free_list.sv
`timescale 1ns/1ps

module free_list (
    input  logic                  clk,
    input  logic                  rst,

    // Allocation side
    input  logic                  alloc,
    output rename_pkg::phys_reg_t alloc_reg,

    // Registers freed at commit
    input  logic                  release_valid,
    input  rename_pkg::phys_reg_t release_reg,

    input  logic                  flush
);

    localparam int FL_DEPTH = rename_pkg::NUM_PHYS - rename_pkg::NUM_ARCH;
    localparam int PTR_W    = $clog2(FL_DEPTH);

    rename_pkg::phys_reg_t fl_mem [FL_DEPTH];

    // head: next register to hand out
    // tail: slot for the next freed register
    // ret:  head position as of the last committed allocation
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W-1:0] ret_q;
    logic [PTR_W-1:0] ret_next;

    // Head register is visible without waiting for alloc
    assign alloc_reg = fl_mem[head_q];

    // Each commit with a destination retires one allocation
    assign ret_next = release_valid ? ret_q + 1'b1 : ret_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
            ret_q  <= '0;
        end else begin
            if (flush) begin
                // Reclaim registers taken by squashed instructions
                head_q <= ret_next;
            end else if (alloc) begin
                head_q <= head_q + 1'b1;
            end

            if (release_valid) begin
                tail_q <= tail_q + 1'b1;
            end
            ret_q <= ret_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // List starts full with every register above the architectural set
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= rename_pkg::phys_reg_t'(rename_pkg::NUM_ARCH + i);
            end
        end else if (release_valid) begin
            fl_mem[tail_q] <= release_reg;
        end
    end

endmodule

// File: reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,

    // Dispatch side
    input  logic                  push,
    input  rename_pkg::renamed_t  push_entry,
    input  rename_pkg::arch_reg_t push_rd,
    output rename_pkg::rob_id_t   tail_id,

    // Completion from the execution units
    input  logic                  complete_valid,
    input  rename_pkg::rob_id_t   complete_id,

    input  logic                  flush,

    // Commit side
    output logic                  commit_valid,
    output rename_pkg::commit_t   commit_info,
    output logic                  credit_return
);

    localparam int PTR_W = $clog2(ROB_DEPTH);

    rename_pkg::commit_t ent_q [ROB_DEPTH];

    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] done_q;
    logic [PTR_W-1:0]     head_q;
    logic [PTR_W-1:0]     tail_q;
    logic [PTR_W-1:0]     cmp_idx;
    logic                 pop;

    assign tail_id = rename_pkg::rob_id_t'(tail_q);
    assign cmp_idx = PTR_W'(complete_id);

    // Head retires once it has finished, never during a flush
    assign pop = valid_q[head_q] && done_q[head_q] && !flush;

    assign commit_valid  = pop;
    assign commit_info   = ent_q[head_q];
    assign credit_return = pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else if (flush) begin
            // Squash everything in flight
            valid_q <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (push) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end

            // Late completions for empty slots are ignored
            if (complete_valid && valid_q[cmp_idx]) begin
                done_q[cmp_idx] <= 1'b1;
            end

            if (pop) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
        end
    end

    // Only what commit needs is kept per entry
    always_ff @(posedge clk) begin
        if (push) begin
            ent_q[tail_q] <= '{
                rd:      push_rd,
                prd:     push_entry.prd,
                old_prd: push_entry.old_prd
            };
        end
    end

endmodule

// File: rename_dispatch.sv
`timescale 1ns/1ps

module rename_dispatch (
    input  logic                  clk,
    input  logic                  rst,

    // Upstream, credit based
    input  logic                  in_valid,
    input  rename_pkg::ren_inst_t in_inst,
    input  logic                  flush,

    // Speculative map lookups and update
    output rename_pkg::arch_reg_t map_rs1,
    output rename_pkg::arch_reg_t map_rs2,
    output rename_pkg::arch_reg_t map_rd,
    input  rename_pkg::phys_reg_t map_prs1,
    input  rename_pkg::phys_reg_t map_prs2,
    input  rename_pkg::phys_reg_t map_old_prd,
    output logic                  map_we,
    output rename_pkg::phys_reg_t map_new_prd,

    // Free list
    output logic                  alloc,
    input  rename_pkg::phys_reg_t alloc_reg,

    // Reorder buffer
    output logic                  push,
    output rename_pkg::renamed_t  push_entry,
    output rename_pkg::arch_reg_t push_rd,
    input  rename_pkg::rob_id_t   tail_id,

    // Renamed instruction out
    output logic                  ren_valid,
    output rename_pkg::renamed_t  ren_out
);

    logic accept;
    logic has_rd;

    assign accept = in_valid && !flush;
    assign has_rd = in_inst.rd != '0;

    assign map_rs1 = in_inst.rs1;
    assign map_rs2 = in_inst.rs2;
    assign map_rd  = in_inst.rd;

    // x0 destinations take no register and leave the map alone
    assign alloc       = accept && has_rd;
    assign map_we      = accept && has_rd;
    assign map_new_prd = alloc_reg;

    assign push    = accept;
    assign push_rd = in_inst.rd;

    always_comb begin
        push_entry.rob_id  = tail_id;
        push_entry.prd     = has_rd ? alloc_reg : '0;
        push_entry.prs1    = map_prs1;
        push_entry.prs2    = map_prs2;
        push_entry.old_prd = has_rd ? map_old_prd : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ren_valid <= 1'b0;
        end else begin
            ren_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ren_out <= push_entry;
        end
    end

endmodule

// File: rename_unit.sv
`timescale 1ns/1ps

module rename_unit #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  in_valid,
    input  rename_pkg::ren_inst_t in_inst,
    input  logic                  flush,

    input  logic                  complete_valid,
    input  rename_pkg::rob_id_t   complete_id,

    output logic                  ren_valid,
    output rename_pkg::renamed_t  ren_out,

    output logic                  commit_valid,
    output rename_pkg::commit_t   commit_info,
    output logic                  credit_return
);

    // Dispatch to speculative map
    rename_pkg::arch_reg_t map_rs1;
    rename_pkg::arch_reg_t map_rs2;
    rename_pkg::arch_reg_t map_rd;
    rename_pkg::phys_reg_t map_prs1;
    rename_pkg::phys_reg_t map_prs2;
    rename_pkg::phys_reg_t map_old_prd;
    logic                  map_we;
    rename_pkg::phys_reg_t map_new_prd;

    // Dispatch to free list and reorder buffer
    logic                  alloc;
    rename_pkg::phys_reg_t alloc_reg;
    logic                  push;
    rename_pkg::renamed_t  push_entry;
    rename_pkg::arch_reg_t push_rd;
    rename_pkg::rob_id_t   tail_id;

    rename_pkg::map_vec_t  retired_map;

    rename_dispatch u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .flush       (flush),
        .map_rs1     (map_rs1),
        .map_rs2     (map_rs2),
        .map_rd      (map_rd),
        .map_prs1    (map_prs1),
        .map_prs2    (map_prs2),
        .map_old_prd (map_old_prd),
        .map_we      (map_we),
        .map_new_prd (map_new_prd),
        .alloc       (alloc),
        .alloc_reg   (alloc_reg),
        .push        (push),
        .push_entry  (push_entry),
        .push_rd     (push_rd),
        .tail_id     (tail_id),
        .ren_valid   (ren_valid),
        .ren_out     (ren_out)
    );

    spec_map_table u_spec_map (
        .clk         (clk),
        .rst         (rst),
        .rs1         (map_rs1),
        .rs2         (map_rs2),
        .rd          (map_rd),
        .prs1        (map_prs1),
        .prs2        (map_prs2),
        .old_prd     (map_old_prd),
        .map_we      (map_we),
        .new_prd     (map_new_prd),
        .flush       (flush),
        .retired_map (retired_map)
    );

    retire_map_table u_retire_map (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit_info  (commit_info),
        .retired_map  (retired_map)
    );

    // Old mapping of a committed rd goes back on the list
    free_list u_free_list (
        .clk           (clk),
        .rst           (rst),
        .alloc         (alloc),
        .alloc_reg     (alloc_reg),
        .release_valid (commit_valid && (commit_info.rd != '0)),
        .release_reg   (commit_info.old_prd),
        .flush         (flush)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk            (clk),
        .rst            (rst),
        .push           (push),
        .push_entry     (push_entry),
        .push_rd        (push_rd),
        .tail_id        (tail_id),
        .complete_valid (complete_valid),
        .complete_id    (complete_id),
        .flush          (flush),
        .commit_valid   (commit_valid),
        .commit_info    (commit_info),
        .credit_return  (credit_return)
    );

endmodule

// File: rename_unit_tb.sv
`timescale 1ns/1ps

module rename_unit_tb;

    localparam int ROB_DEPTH     = 8;
    localparam int FL_DEPTH      = rename_pkg::NUM_PHYS - rename_pkg::NUM_ARCH;
    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 5;
    localparam int OPEN_CYCLES   = 6;
    localparam int RANDOM_CYCLES = 400;
    localparam int FLUSH_CYCLES  = 300;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + OPEN_CYCLES + RANDOM_CYCLES + FLUSH_CYCLES + 60;

    // One in-flight instruction as the model sees it
    typedef struct packed {
        rename_pkg::rob_id_t id;
        rename_pkg::commit_t info;
        logic                done;
    } model_entry_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  in_valid;
    rename_pkg::ren_inst_t in_inst;
    logic                  flush;
    logic                  complete_valid;
    rename_pkg::rob_id_t   complete_id;
    logic                  ren_valid;
    rename_pkg::renamed_t  ren_out;
    logic                  commit_valid;
    rename_pkg::commit_t   commit_info;
    logic                  credit_return;

    // Reference model
    rename_pkg::phys_reg_t spec_map [rename_pkg::NUM_ARCH];
    rename_pkg::phys_reg_t ret_map [rename_pkg::NUM_ARCH];
    rename_pkg::phys_reg_t fl_regs [FL_DEPTH];
    int                    fl_head;
    int                    fl_tail;
    int                    fl_ret;
    model_entry_t          rob_q [$];
    int                    rob_tail;
    int                    credits;
    logic                  exp_ren_valid;
    rename_pkg::renamed_t  exp_ren_out;
    logic                  commit_due;

    int checks;
    int errors;
    int alloc_count;
    int commit_count;
    int flush_count;
    int busy_flushes;

    rename_unit #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_dut (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_inst        (in_inst),
        .flush          (flush),
        .complete_valid (complete_valid),
        .complete_id    (complete_id),
        .ren_valid      (ren_valid),
        .ren_out        (ren_out),
        .commit_valid   (commit_valid),
        .commit_info    (commit_info),
        .credit_return  (credit_return)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_port(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("mismatch at %0t: %s expected 0x%0h got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic verify_rule(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error at %0t: %s", $time, what);
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < rename_pkg::NUM_ARCH; i++) begin
            spec_map[i] = rename_pkg::phys_reg_t'(i);
            ret_map[i]  = rename_pkg::phys_reg_t'(i);
        end
        for (int i = 0; i < FL_DEPTH; i++) begin
            fl_regs[i] = rename_pkg::phys_reg_t'(rename_pkg::NUM_ARCH + i);
        end
        fl_head       = 0;
        fl_tail       = 0;
        fl_ret        = 0;
        rob_tail      = 0;
        credits       = ROB_DEPTH;
        exp_ren_valid = 1'b0;
        commit_due    = 1'b0;
        rob_q.delete();
    endtask

    task automatic check_outputs();
        model_entry_t head_ent;
        commit_due = 1'b0;
        if (!flush && rob_q.size() > 0) begin
            head_ent   = rob_q[0];
            commit_due = head_ent.done;
        end
        compare_port("ren_valid", exp_ren_valid, ren_valid);
        if (exp_ren_valid) begin
            compare_port("ren_out", exp_ren_out, ren_out);
        end
        compare_port("commit_valid", commit_due, commit_valid);
        compare_port("credit_return", commit_due, credit_return);
        if (commit_due) begin
            compare_port("commit_info", head_ent.info, commit_info);
        end
    endtask

    // Applies this cycle's inputs the way the next clock edge does
    task automatic advance_model();
        model_entry_t         ent;
        model_entry_t         new_ent;
        rename_pkg::renamed_t ren;
        credits = credits - int'(in_valid) + int'(credit_return);
        verify_rule(credits >= 0 && credits <= ROB_DEPTH,
                    "upstream credit count left the range 0 to ROB_DEPTH");
        if (flush) begin
            if (rob_q.size() > 0) begin
                busy_flushes++;
            end
            flush_count++;
            rob_q.delete();
            for (int i = 0; i < rename_pkg::NUM_ARCH; i++) begin
                spec_map[i] = ret_map[i];
            end
            fl_head       = fl_ret;
            rob_tail      = 0;
            credits       = ROB_DEPTH;
            exp_ren_valid = 1'b0;
        end else begin
            exp_ren_valid = in_valid;
            if (in_valid) begin
                ren.rob_id = rename_pkg::rob_id_t'(rob_tail);
                ren.prs1   = spec_map[in_inst.rs1];
                ren.prs2   = spec_map[in_inst.rs2];
                ren.prd     = '0;
                ren.old_prd = '0;
                if (in_inst.rd != '0) begin
                    ren.prd              = fl_regs[fl_head];
                    ren.old_prd          = spec_map[in_inst.rd];
                    fl_head              = (fl_head + 1) % FL_DEPTH;
                    spec_map[in_inst.rd] = ren.prd;
                    alloc_count++;
                end
                exp_ren_out = ren;
                new_ent     = '{id: ren.rob_id, info: '{rd: in_inst.rd, prd: ren.prd,
                                old_prd: ren.old_prd}, done: 1'b0};
            end
            if (complete_valid) begin
                for (int i = 0; i < rob_q.size(); i++) begin
                    ent = rob_q[i];
                    if (ent.id == complete_id) begin
                        ent.done = 1'b1;
                        rob_q[i] = ent;
                    end
                end
            end
            if (commit_due) begin
                ent = rob_q.pop_front();
                commit_count++;
                if (ent.info.rd != '0) begin
                    ret_map[ent.info.rd] = ent.info.prd;
                    fl_regs[fl_tail]     = ent.info.old_prd;
                    fl_tail              = (fl_tail + 1) % FL_DEPTH;
                    fl_ret               = (fl_ret + 1) % FL_DEPTH;
                end
            end
            if (in_valid) begin
                rob_q.push_back(new_ent);
                rob_tail = (rob_tail + 1) % ROB_DEPTH;
            end
        end
        verify_rule(credits + rob_q.size() == ROB_DEPTH,
                    "credits out of step with entries in flight");
    endtask

    // Inputs for the next cycle, chosen from the model state
    task automatic drive_cycle(input logic dispatch_on, input logic complete_on,
                               input int flush_odds);
        rename_pkg::ren_inst_t inst;
        model_entry_t          ent;
        int                    pending;
        int                    pick;
        @(posedge clk);
        inst.rd  = ($urandom % 8 == 0) ? '0 : rename_pkg::arch_reg_t'(1 + $urandom % 31);
        inst.rs1 = rename_pkg::arch_reg_t'($urandom % 32);
        inst.rs2 = rename_pkg::arch_reg_t'($urandom % 32);
        in_inst  <= inst;
        in_valid <= dispatch_on && credits > 0 && ($urandom % 4 != 0);
        pending = 0;
        for (int i = 0; i < rob_q.size(); i++) begin
            ent = rob_q[i];
            if (!ent.done) begin
                pending++;
            end
        end
        complete_valid <= 1'b0;
        if (complete_on && pending > 0 && $urandom % 2 == 0) begin
            pick = int'($urandom % pending);
            for (int i = 0; i < rob_q.size(); i++) begin
                ent = rob_q[i];
                if (!ent.done) begin
                    if (pick == 0) begin
                        complete_valid <= 1'b1;
                        complete_id    <= ent.id;
                    end
                    pick--;
                end
            end
        end
        flush <= (flush_odds > 0) && ($urandom % flush_odds == 0);
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_outputs();
            advance_model();
        end
    end

    initial begin
        void'($urandom(32'h4d10));
        rst            = 1'b1;
        in_valid       = 1'b0;
        in_inst        = '0;
        flush          = 1'b0;
        complete_valid = 1'b0;
        complete_id    = '0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // Identity map and no commits before any completion
        repeat (OPEN_CYCLES) drive_cycle(1'b1, 1'b0, 0);
        // Long run wraps the free list
        repeat (RANDOM_CYCLES) drive_cycle(1'b1, 1'b1, 0);
        // Flush with entries still in flight
        repeat (3) drive_cycle(1'b1, 1'b0, 0);
        drive_cycle(1'b1, 1'b1, 1);
        repeat (FLUSH_CYCLES) drive_cycle(1'b1, 1'b1, 25);
        while (rob_q.size() != 0) begin
            drive_cycle(1'b0, 1'b1, 0);
        end
        repeat (4) drive_cycle(1'b0, 1'b0, 0);
        @(posedge clk);

        verify_rule(credits == ROB_DEPTH, "credits did not return to full after the drain");
        verify_rule(alloc_count > FL_DEPTH, "free list never wrapped around");
        verify_rule(busy_flushes > 0, "no flush found entries in flight");
        $display("checks %0d, errors %0d, allocations %0d, commits %0d, flushes %0d",
                 checks, errors, alloc_count, commit_count, flush_count);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(20 * TOTAL_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", 20 * TOTAL_CYCLES);
        $display("checks %0d, errors %0d", checks, errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: rename_unit.f
rename_pkg.sv
spec_map_table.sv
retire_map_table.sv
free_list.sv
reorder_buffer.sv
rename_dispatch.sv
rename_unit.sv
rename_unit_tb.sv
